// ==== pelletPkg.sv ====
`default_nettype none

package pelletPkg;

    typedef logic [9:0] coordT;
    typedef logic [15:0] scoreT;
    typedef logic [3:0] sizeT;

    // visible screen area
    localparam int ScreenWidth = 640;
    localparam int ScreenHeight = 480;

    localparam sizeT PelletRadius = 4'd4;
    localparam sizeT PlayerSizeInit = 4'd4;
    localparam sizeT PlayerSizeMin = 4'd1;
    localparam sizeT PlayerSizeMax = 4'd10;

    // respawn coordinates keep only these low bits of the random value
    localparam int RespawnXBits = 9;
    localparam int RespawnYBits = 8;

    localparam int MaxPellets = 16;

    // reset positions, indexed by pellet
    localparam coordT pelletStartX [MaxPellets] = '{
        10'd150, 10'd400, 10'd17,  10'd455,
        10'd66,  10'd602, 10'd89,  10'd634,
        10'd200, 10'd300, 10'd100, 10'd12,
        10'd543, 10'd45,  10'd625, 10'd77
    };

    localparam coordT pelletStartY [MaxPellets] = '{
        10'd300, 10'd89,  10'd58,  10'd300,
        10'd88,  10'd38,  10'd120, 10'd79,
        10'd66,  10'd99,  10'd130, 10'd7,
        10'd400, 10'd69,  10'd5,   10'd92
    };

endpackage

`default_nettype wire

// ==== pelletStore.sv ====
`timescale 1ns/1ps
`default_nettype none

module pelletStore
#(
    parameter int NumPellets = 16
)
(
    input  logic                   Clk,
    input  logic                   rstN,
    input  logic                   frameUpdate,
    input  logic [NumPellets-1:0]  hitMask,
    input  pelletPkg::coordT       randomX,
    input  pelletPkg::coordT       randomY,
    output pelletPkg::coordT       pelletX [NumPellets],
    output pelletPkg::coordT       pelletY [NumPellets]
);

    import pelletPkg::*;

    coordT respawnX;
    coordT respawnY;

    // keep respawns inside the screen, x below 512 and y below 256
    assign respawnX = coordT'(randomX[RespawnXBits-1:0]);
    assign respawnY = coordT'(randomY[RespawnYBits-1:0]);

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < NumPellets; i++)
            begin
                pelletX[i] <= pelletStartX[i];
                pelletY[i] <= pelletStartY[i];
            end
        end
        else if (frameUpdate)
        begin
            // only pellets the player touched move
            for (int i = 0; i < NumPellets; i++)
            begin
                if (hitMask[i])
                begin
                    pelletX[i] <= respawnX;
                    pelletY[i] <= respawnY;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== pelletCollide.sv ====
`timescale 1ns/1ps
`default_nettype none

module pelletCollide
#(
    parameter int NumPellets = 16
)
(
    input  logic [9:0]             playerX,
    input  logic [9:0]             playerY,
    input  pelletPkg::coordT       pelletX [NumPellets],
    input  pelletPkg::coordT       pelletY [NumPellets],
    input  pelletPkg::sizeT        playerSize,
    output logic [NumPellets-1:0]  hitMask
);

    import pelletPkg::*;

    logic [4:0] reach;
    logic [9:0] reachSq;

    // touching when centres are closer than the two radii together
    assign reach = 5'(PelletRadius) + 5'(playerSize);
    assign reachSq = reach * reach;

    for (genvar i = 0; i < NumPellets; i++)
    begin : gPellet
        logic signed [10:0] dx;
        logic signed [10:0] dy;
        logic [21:0] dxSq;
        logic [21:0] dySq;
        logic [21:0] distSq;

        assign dx = $signed({1'b0, playerX}) - $signed({1'b0, pelletX[i]});
        assign dy = $signed({1'b0, playerY}) - $signed({1'b0, pelletY[i]});
        assign dxSq = dx * dx;
        assign dySq = dy * dy;
        assign distSq = dxSq + dySq;

        assign hitMask[i] = (distSq <= 22'(reachSq));
    end

endmodule

`default_nettype wire

// ==== gameStateCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module gameStateCtrl
#(
    parameter int NumPellets = 16
)
(
    input  logic                   Clk,
    input  logic                   rstN,
    input  logic                   frameTick,
    input  logic                   startGame,
    input  logic [NumPellets-1:0]  hitMask,
    output logic                   frameUpdate,
    output logic                   growHit,
    output logic                   shrinkHit,
    output pelletPkg::scoreT       score,
    output pelletPkg::sizeT        playerSize
);

    import pelletPkg::*;

    localparam int HalfPellets = NumPellets / 2;

    logic tickPrev;

    // starts high so a tick already up at reset release is ignored
    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
            tickPrev <= 1'b1;
        else
            tickPrev <= frameTick;
    end

    assign frameUpdate = frameTick && !tickPrev;

    // lower half grows, upper half shrinks
    assign growHit = |hitMask[HalfPellets-1:0];
    assign shrinkHit = |hitMask[NumPellets-1:HalfPellets];

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            score <= '0;
            playerSize <= PlayerSizeInit;
        end
        else if (frameUpdate)
        begin
            if (growHit)
            begin
                score <= score + 1'b1;
                if (playerSize < PlayerSizeMax)
                    playerSize <= playerSize + sizeT'(1);
            end
            else if (shrinkHit)
            begin
                score <= score + 1'b1;
                if (playerSize > PlayerSizeMin)
                    playerSize <= playerSize - sizeT'(1);
            end
            else if (startGame)
            begin
                score <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== pelletRaster.sv ====
`timescale 1ns/1ps
`default_nettype none

module pelletRaster
#(
    parameter int NumPellets = 16
)
(
    input  pelletPkg::coordT       drawX,
    input  pelletPkg::coordT       drawY,
    input  pelletPkg::coordT       pelletX [NumPellets],
    input  pelletPkg::coordT       pelletY [NumPellets],
    output logic [NumPellets-1:0]  pelletPixel
);

    import pelletPkg::*;

    localparam logic [21:0] RadiusSq = 22'(PelletRadius) * 22'(PelletRadius);

    logic onScreen;

    // blanking area never shows a pellet
    assign onScreen = (drawX < ScreenWidth) && (drawY < ScreenHeight);

    for (genvar i = 0; i < NumPellets; i++)
    begin : gPellet
        logic signed [10:0] dx;
        logic signed [10:0] dy;
        logic [21:0] dxSq;
        logic [21:0] dySq;

        assign dx = $signed({1'b0, drawX}) - $signed({1'b0, pelletX[i]});
        assign dy = $signed({1'b0, drawY}) - $signed({1'b0, pelletY[i]});
        assign dxSq = dx * dx;
        assign dySq = dy * dy;

        assign pelletPixel[i] = onScreen && ((dxSq + dySq) <= RadiusSq);
    end

endmodule

`default_nettype wire

// ==== pelletGameTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module pelletGameTop
#(
    parameter int NumPellets = 16
)
(
    input  logic                   Clk,
    input  logic                   rstN,
    input  logic                   frameTick,
    input  pelletPkg::coordT       playerX,
    input  pelletPkg::coordT       playerY,
    input  pelletPkg::coordT       randomX,
    input  pelletPkg::coordT       randomY,
    input  logic                   startGame,
    input  pelletPkg::coordT       drawX,
    input  pelletPkg::coordT       drawY,
    output logic                   growHit,
    output logic                   shrinkHit,
    output pelletPkg::scoreT       score,
    output pelletPkg::sizeT        playerSize,
    output logic [NumPellets-1:0]  pelletPixel
);

    import pelletPkg::*;

    logic frameUpdate;
    logic [NumPellets-1:0] hitMask;
    coordT pelletX [NumPellets];
    coordT pelletY [NumPellets];

    pelletStore #(
        .NumPellets (NumPellets)
    ) pelletStore_i (
        .Clk         (Clk),
        .rstN        (rstN),
        .frameUpdate (frameUpdate),
        .hitMask     (hitMask),
        .randomX     (randomX),
        .randomY     (randomY),
        .pelletX     (pelletX),
        .pelletY     (pelletY)
    );

    pelletCollide #(
        .NumPellets (NumPellets)
    ) pelletCollide_i (
        .playerX    (playerX),
        .playerY    (playerY),
        .pelletX    (pelletX),
        .pelletY    (pelletY),
        .playerSize (playerSize),
        .hitMask    (hitMask)
    );

    gameStateCtrl #(
        .NumPellets (NumPellets)
    ) gameStateCtrl_i (
        .Clk         (Clk),
        .rstN        (rstN),
        .frameTick   (frameTick),
        .startGame   (startGame),
        .hitMask     (hitMask),
        .frameUpdate (frameUpdate),
        .growHit     (growHit),
        .shrinkHit   (shrinkHit),
        .score       (score),
        .playerSize  (playerSize)
    );

    pelletRaster #(
        .NumPellets (NumPellets)
    ) pelletRaster_i (
        .drawX       (drawX),
        .drawY       (drawY),
        .pelletX     (pelletX),
        .pelletY     (pelletY),
        .pelletPixel (pelletPixel)
    );

endmodule

`default_nettype wire

// ==== pelletGameAssertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module pelletGameAssertions
(
    input logic                    Clk,
    input logic                    rstN,
    input logic                    frameTick,
    input logic                    startGame,
    input logic                    growHit,
    input logic                    shrinkHit,
    input pelletPkg::scoreT        score,
    input pelletPkg::sizeT         playerSize
);

    import pelletPkg::*;

    // a frame update lands on the edge where frameTick is first seen high
    sizeGrow: assert property (@(posedge Clk) disable iff (!rstN)
        ($rose(frameTick) && growHit) |=>
            (playerSize == (($past(playerSize) < PlayerSizeMax) ?
                $past(playerSize) + 4'd1 : PlayerSizeMax)))
        else $error("playerSize did not grow on a grow hit");

    sizeShrink: assert property (@(posedge Clk) disable iff (!rstN)
        ($rose(frameTick) && !growHit && shrinkHit) |=>
            (playerSize == (($past(playerSize) > PlayerSizeMin) ?
                $past(playerSize) - 4'd1 : PlayerSizeMin)))
        else $error("playerSize did not shrink on a shrink hit");

    sizeHold: assert property (@(posedge Clk) disable iff (!rstN)
        !($rose(frameTick) && (growHit || shrinkHit)) |=> $stable(playerSize))
        else $error("playerSize changed without a hit at a frame update");

    sizeRange: assert property (@(posedge Clk) disable iff (!rstN)
        (playerSize >= PlayerSizeMin) && (playerSize <= PlayerSizeMax))
        else $error("playerSize left the range 1 to 10");

    // any hit counts once, whatever the group
    scoreHit: assert property (@(posedge Clk) disable iff (!rstN)
        ($rose(frameTick) && (growHit || shrinkHit)) |=> (score == $past(score) + 16'd1))
        else $error("score did not rise by one on a hit");

    scoreClear: assert property (@(posedge Clk) disable iff (!rstN)
        ($rose(frameTick) && !growHit && !shrinkHit && startGame) |=> (score == '0))
        else $error("score not cleared by startGame");

endmodule

bind pelletGameTop pelletGameAssertions pelletGameAssertions_i (
    .Clk        (Clk),
    .rstN       (rstN),
    .frameTick  (frameTick),
    .startGame  (startGame),
    .growHit    (growHit),
    .shrinkHit  (shrinkHit),
    .score      (score),
    .playerSize (playerSize)
);

`default_nettype wire

// ==== pelletGameTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pelletGameTb;

    import pelletPkg::*;

    localparam int NumPellets = 16;
    localparam int ClkPeriod = 8;
    localparam int NumTests = 6;
    // tests x frames x cycles per frame x period
    localparam int TimeoutNs = NumTests * 20 * 10 * ClkPeriod;
    localparam int GrowTarget = 0;
    localparam int ShrinkTarget = 8;
    // respawn spots stay this far from every pellet, squared
    localparam int ClearMarginSq = 400;
    localparam int MaxTries = 200;

    logic Clk;
    logic rstN;
    logic frameTick;
    coordT playerX;
    coordT playerY;
    coordT randomX;
    coordT randomY;
    logic startGame;
    coordT drawX;
    coordT drawY;
    logic growHit;
    logic shrinkHit;
    scoreT score;
    sizeT playerSize;
    logic [NumPellets-1:0] pelletPixel;

    // where each pellet should be right now
    coordT expX [NumPellets];
    coordT expY [NumPellets];
    int expScore;
    int expSize;

    pelletGameTop #(
        .NumPellets (NumPellets)
    ) pelletGameTop_i (
        .Clk         (Clk),
        .rstN        (rstN),
        .frameTick   (frameTick),
        .playerX     (playerX),
        .playerY     (playerY),
        .randomX     (randomX),
        .randomY     (randomY),
        .startGame   (startGame),
        .drawX       (drawX),
        .drawY       (drawY),
        .growHit     (growHit),
        .shrinkHit   (shrinkHit),
        .score       (score),
        .playerSize  (playerSize),
        .pelletPixel (pelletPixel)
    );

    initial
    begin
        Clk = 1'b0;
        forever #(ClkPeriod / 2) Clk = ~Clk;
    end

    initial
    begin
        #(TimeoutNs);
        $display("Timeout after %0d ns, the test sequence never reached its end", TimeoutNs);
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

    task automatic stopOnFailure(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compareValue(input string sigName, input int got, input int expected);
        assert (got == expected)
        else
            stopOnFailure($sformatf("Mismatch at %0t: %s got %0d expected %0d",
                $time, sigName, got, expected));
    endtask

    // inputs change shortly after the rising edge
    task automatic nextDriveSlot();
        @(posedge Clk);
        #1;
    endtask

    task automatic frameStep();
        nextDriveSlot();
        frameTick = 1'b1;
        nextDriveSlot();
        frameTick = 1'b0;
    endtask

    task automatic checkPixel(input int idx, input coordT x, input coordT y, input logic expBit);
        nextDriveSlot();
        drawX = x;
        drawY = y;
        #2;
        compareValue($sformatf("pelletPixel[%0d]", idx), int'(pelletPixel[idx]), int'(expBit));
    endtask

    // random spot, once masked, must be clear of all pellets
    task automatic chooseRespawn(output coordT rx, output coordT ry);
        coordT cx;
        coordT cy;
        int dx;
        int dy;
        int tries;
        logic found;
        found = 1'b0;
        tries = 0;
        while (!found && tries < MaxTries)
        begin
            rx = coordT'($urandom);
            ry = coordT'($urandom);
            cx = rx & 10'h1ff;
            cy = ry & 10'h0ff;
            found = 1'b1;
            for (int j = 0; j < NumPellets; j++)
            begin
                dx = int'(cx) - int'(expX[j]);
                dy = int'(cy) - int'(expY[j]);
                if (dx * dx + dy * dy <= ClearMarginSq)
                    found = 1'b0;
            end
            tries++;
        end
        if (!found)
            stopOnFailure("No free respawn spot found among the random values");
    endtask

    // player onto a pellet, one frame, then look for the respawn
    task automatic hitPellet(input int idx);
        coordT rx;
        coordT ry;
        logic isGrow;
        isGrow = (idx < NumPellets / 2);
        chooseRespawn(rx, ry);
        nextDriveSlot();
        playerX = expX[idx];
        playerY = expY[idx];
        randomX = rx;
        randomY = ry;
        #2;
        compareValue("growHit", int'(growHit), int'(isGrow));
        compareValue("shrinkHit", int'(shrinkHit), int'(!isGrow));
        frameStep();
        expScore++;
        if (isGrow && expSize < int'(PlayerSizeMax))
            expSize++;
        else if (!isGrow && expSize > int'(PlayerSizeMin))
            expSize--;
        expX[idx] = rx & 10'h1ff;
        expY[idx] = ry & 10'h0ff;
        compareValue("score", int'(score), expScore);
        compareValue("playerSize", int'(playerSize), expSize);
        checkPixel(idx, expX[idx], expY[idx], 1'b1);
    endtask

    initial
    begin
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(32'h37bb));
        rstN = 1'b0;
        frameTick = 1'b0;
        playerX = 10'd630;
        playerY = 10'd470;
        randomX = '0;
        randomY = '0;
        startGame = 1'b0;
        drawX = '0;
        drawY = '0;
        for (int i = 0; i < NumPellets; i++)
        begin
            expX[i] = pelletStartX[i];
            expY[i] = pelletStartY[i];
        end
        expScore = 0;
        expSize = 4;

        repeat (3) @(posedge Clk);
        #1;
        rstN = 1'b1;

        // reset state
        nextDriveSlot();
        compareValue("score", int'(score), 0);
        compareValue("playerSize", int'(playerSize), 4);

        // every pellet covers its centre and 3 px to the right, not 10 px
        for (int i = 0; i < NumPellets; i++)
        begin
            checkPixel(i, pelletStartX[i], pelletStartY[i], 1'b1);
            checkPixel(i, pelletStartX[i] + 10'd3, pelletStartY[i], 1'b1);
            checkPixel(i, pelletStartX[i] + 10'd10, pelletStartY[i], 1'b0);
        end

        hitPellet(GrowTarget);

        // up to the largest size, one extra frame to hit the ceiling
        repeat (int'(PlayerSizeMax) - expSize + 1) hitPellet(GrowTarget);

        // a frame with no hit keeps the score, then startGame clears it
        nextDriveSlot();
        playerX = 10'd630;
        playerY = 10'd470;
        #2;
        compareValue("growHit", int'(growHit), 0);
        compareValue("shrinkHit", int'(shrinkHit), 0);
        frameStep();
        compareValue("score", int'(score), expScore);
        nextDriveSlot();
        startGame = 1'b1;
        frameStep();
        expScore = 0;
        compareValue("score", int'(score), expScore);
        compareValue("playerSize", int'(playerSize), expSize);
        nextDriveSlot();
        startGame = 1'b0;

        // down to the smallest size and one more
        repeat (expSize - int'(PlayerSizeMin) + 1) hitPellet(ShrinkTarget);

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== pelletGameTop.f ====
pelletPkg.sv
pelletStore.sv
pelletCollide.sv
gameStateCtrl.sv
pelletRaster.sv
pelletGameTop.sv
pelletGameAssertions.sv
pelletGameTb.sv

// ==== Makefile ====
# Verilator build and run for the pellet game testbench

VERILATOR ?= verilator
TOP ?= pelletGameTb
FILELIST ?= pelletGameTop.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps -j 0
RUN_FLAGS ?= +verilator+error+limit+1
PASS_TEXT ?= All tests passed!

SIM = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$($(SIM) $(RUN_FLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
